// ==== filelist.f ====
+incdir+include
logic/lc3b_isa_pkg.sv
logic/ooo_pkg.sv
logic/lc3b_alu.sv
logic/alu_res_station.sv
logic/cdb_arbiter.sv
logic/issue_unit.sv
logic/ooo_alu_top.sv
dv/ooo_alu_chk.sv
dv/ooo_alu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert --timing -Wno-fatal --top-module ooo_alu_tb \
	-f filelist.f -o ooo_alu_sim || { echo "Build failed"; exit 1; }
./obj_dir/ooo_alu_sim > sim.log 2>&1
cat sim.log
grep -q "Test failures found" sim.log && { echo "FAIL"; exit 1; }
grep -q "All tests passed!" sim.log || { echo "FAIL: run ended early"; exit 1; }
echo "PASS"

// ==== dv/ooo_alu_tb.sv ====
`default_nettype none
`include "ooo_defs.svh"

module ooo_alu_tb;

	import lc3b_isa_pkg::*;
	import ooo_pkg::*;

	localparam int NUM_INSTR = 400; // Program length
	localparam int WATCHDOG_CYCLES = NUM_INSTR * 20 + 200; // Worst case per instruction plus slack

	logic clk;
	logic rst_n;
	logic issue_valid;
	lc3b_instr_u issue_instr;
	logic issue_ready;
	logic cdb_valid;
	rs_tag_t cdb_tag;
	lc3b_word cdb_data;

	logic [31:0] lcg_state = 32'ha5ac_3963;
	logic [31:0] gap_draw; // Decides whether a cycle carries an instruction
	logic [15:0] accepted_instr;
	lc3b_word arch_regs [`OOO_REG_COUNT]; // In-order register model
	lc3b_word exp_data [`OOO_RS_COUNT]; // Expected broadcast per station tag
	logic [`OOO_RS_COUNT-1:0] tag_pending; // Stations that still owe one broadcast
	rs_tag_t new_tag;
	int sent;
	int retired;

	ooo_alu_top i_dut
	(
		.clk(clk),
		.rst_n(rst_n),
		.issue_valid(issue_valid),
		.issue_instr(issue_instr),
		.issue_ready(issue_ready),
		.cdb_valid(cdb_valid),
		.cdb_tag(cdb_tag),
		.cdb_data(cdb_data)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1);
	endtask

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Only R0..R3 are used so that most instructions depend on a recent one
	function automatic logic [15:0] random_instr();
		logic [31:0] r;
		logic [3:0] op;
		r = lcg_next();
		case (r[31:30])
			2'd0: op = 4'b0001; // ADD
			2'd1: op = 4'b0101; // AND
			2'd2: op = 4'b1001; // NOT
			default: op = 4'b1101; // SHF
		endcase
		if (op == 4'b1101)
			return {op, 1'b0, r[17:16], 1'b0, r[19:18], r[21], r[20], r[27:24]};
		if (op == 4'b1001)
			return {op, 1'b0, r[17:16], 1'b0, r[19:18], 6'b111111};
		if (r[22])
			return {op, 1'b0, r[17:16], 1'b0, r[19:18], 1'b1, r[28:24]}; // imm5 form
		return {op, 1'b0, r[17:16], 1'b0, r[19:18], 3'b000, 1'b0, r[25:24]};
	endfunction

	// Result of one instruction against the in-order register state
	function automatic logic [15:0] expected_result(input logic [15:0] ins);
		logic [15:0] a;
		logic [15:0] b;
		logic [31:0] wide;
		logic [3:0] amt;
		a = arch_regs[ins[8:6]];
		b = ins[5] ? {{11{ins[4]}}, ins[4:0]} : arch_regs[ins[2:0]];
		amt = ins[3:0];
		wide = {{16{a[15]}}, a} >> amt; // Upper copy of the sign feeds the fill
		case (ins[15:12])
			4'b0001: return a + b;
			4'b0101: return a & b;
			4'b1001: return ~a;
			default:
			begin
				if (!ins[4])
					return a << amt;
				else if (!ins[5])
					return a >> amt;
				return wide[15:0];
			end
		endcase
	endfunction

	function automatic rs_tag_t lowest_free(input logic [`OOO_RS_COUNT-1:0] busy);
		rs_tag_t t;
		logic found;
		t = '0;
		found = 1'b0;
		for (int i = 0; i < `OOO_RS_COUNT; i++)
		begin
			if (!found && !busy[i])
			begin
				t = rs_tag_t'(i);
				found = 1'b1;
			end
		end
		return t;
	endfunction

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// **********************************************************************
	// Scoreboard that samples on the edge before any DUT register moves
	// **********************************************************************

	always @(posedge clk)
	begin
		if (rst_n)
		begin
			if (cdb_valid)
			begin
				assert (tag_pending[cdb_tag])
				else
					abort_run($sformatf("Broadcast at t=%0t on tag %0d, which holds no instruction",
						$time, cdb_tag));
				assert (cdb_data == exp_data[cdb_tag])
				else
					abort_run($sformatf("ERR t=%0t cdb_data exp=%h got=%h", $time,
						exp_data[cdb_tag], cdb_data));
				tag_pending[cdb_tag] = 1'b0; // Grant freed it one edge ago
				retired++;
			end
			assert (issue_ready == !(&tag_pending))
			else
				abort_run($sformatf("ERR t=%0t issue_ready exp=%b got=%b", $time,
					!(&tag_pending), issue_ready));
			if (issue_valid && issue_ready)
			begin
				accepted_instr = issue_instr;
				new_tag = lowest_free(tag_pending);
				exp_data[new_tag] = expected_result(accepted_instr);
				arch_regs[accepted_instr[11:9]] = exp_data[new_tag];
				tag_pending[new_tag] = 1'b1;
			end
		end
	end

	always @(negedge clk)
	begin
		if (i_dut.i_chk.fail_seen)
			abort_run("A protocol assertion on the DUT ports failed");
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		abort_run($sformatf("Timeout with %0d of %0d instructions broadcast", retired, NUM_INSTR));
	end

	initial
	begin
		rst_n = 1'b0;
		issue_valid = 1'b0;
		issue_instr = '0;
		tag_pending = '0;
		sent = 0;
		retired = 0;
		for (int i = 0; i < `OOO_REG_COUNT; i++)
			arch_regs[i] = '0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		while (sent < NUM_INSTR)
		begin
			@(posedge clk);
			if (issue_valid && issue_ready)
				sent = sent + 1;
			if (!issue_valid || issue_ready) // A stalled request stays on the port
			begin
				gap_draw = lcg_next();
				if (sent < NUM_INSTR && gap_draw[31:29] != 3'd0)
				begin
					issue_valid <= 1'b1;
					issue_instr <= random_instr();
				end
				else
					issue_valid <= 1'b0;
			end
		end
		while (retired < NUM_INSTR)
			@(negedge clk);
		repeat (10) @(negedge clk); // Stray broadcasts would show up here
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/ooo_alu_chk.sv ====
`default_nettype none

module ooo_alu_chk
(
	input wire logic clk,
	input wire logic rst_n,
	input wire logic issue_valid,
	input wire lc3b_isa_pkg::lc3b_instr_u issue_instr,
	input wire logic issue_ready,
	input wire logic cdb_valid,
	input wire ooo_pkg::rs_tag_t cdb_tag,
	input wire lc3b_isa_pkg::lc3b_word cdb_data
);

	logic fail_seen = 1'b0; // Sticky flag that any failing property below sets

	// **********************************************************************
	// Reset state and CDB ordering
	// **********************************************************************

	// Idle CDB and all stations free on the first cycle out of reset
	a_reset_idle: assert property (@(posedge clk) $rose(rst_n) |-> !cdb_valid && issue_ready)
	else
	begin
		fail_seen = 1'b1;
		$error("ERR t=%0t cdb_valid,issue_ready exp=0,1 got=%b,%b", $time,
			$sampled(cdb_valid), $sampled(issue_ready));
	end

	// A freed station needs a load and a compute cycle before it can broadcast again
	a_tag_repeat: assert property (@(posedge clk) disable iff (!rst_n)
		cdb_valid && $past(cdb_valid) |-> cdb_tag != $past(cdb_tag))
	else
	begin
		fail_seen = 1'b1;
		$error("ERR t=%0t cdb_tag exp=not %0d got=%0d", $time,
			$past(cdb_tag), $sampled(cdb_tag));
	end

	a_cdb_known: assert property (@(posedge clk) disable iff (!rst_n)
		cdb_valid |-> !$isunknown(cdb_tag) && !$isunknown(cdb_data))
	else
	begin
		fail_seen = 1'b1;
		$error("CDB broadcast with an unknown tag or data word");
	end

	// A full station array only drains through a grant, whose word is on the CDB one edge later
	a_free_by_grant: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(issue_ready) |-> cdb_valid)
	else
	begin
		fail_seen = 1'b1;
		$error("ERR t=%0t cdb_valid exp=1 got=%b", $time, $sampled(cdb_valid));
	end

endmodule

bind ooo_alu_top ooo_alu_chk i_chk
(
	.clk(clk),
	.rst_n(rst_n),
	.issue_valid(issue_valid),
	.issue_instr(issue_instr),
	.issue_ready(issue_ready),
	.cdb_valid(cdb_valid),
	.cdb_tag(cdb_tag),
	.cdb_data(cdb_data)
);

`default_nettype wire

// ==== logic/ooo_alu_top.sv ====
`default_nettype none
`include "ooo_defs.svh"

module ooo_alu_top
(
	input wire logic clk,
	input wire logic rst_n,
	input wire logic issue_valid,
	input wire lc3b_isa_pkg::lc3b_instr_u issue_instr,
	output logic issue_ready,
	output logic cdb_valid,
	output ooo_pkg::rs_tag_t cdb_tag,
	output lc3b_isa_pkg::lc3b_word cdb_data
);

	import lc3b_isa_pkg::*;
	import ooo_pkg::*;

	// Issue broadcast that the one-hot load qualifies per station
	logic [`OOO_RS_COUNT-1:0] rs_busy;
	logic [`OOO_RS_COUNT-1:0] rs_load;
	lc3b_aluop rs_aluop;
	rs_tag_t rs_dest;
	lc3b_word rs_vj;
	rs_tag_t rs_qj;
	logic rs_vj_valid;
	lc3b_word rs_vk;
	rs_tag_t rs_qk;
	logic rs_vk_valid;

	// Station results toward the arbiter
	logic [`OOO_RS_COUNT-1:0] result_valid;
	lc3b_word result_data [`OOO_RS_COUNT];
	logic [`OOO_RS_COUNT-1:0] grant;

	issue_unit i_issue
	(
		.clk, .rst_n, .issue_valid, .issue_instr, .issue_ready,
		.rs_busy, .rs_load, .rs_aluop, .rs_dest,
		.rs_vj, .rs_qj, .rs_vj_valid, .rs_vk, .rs_qk, .rs_vk_valid,
		.cdb_valid, .cdb_tag, .cdb_data
	);

	// **********************************************************************
	// Reservation station array
	// **********************************************************************

	for (genvar i = 0; i < `OOO_RS_COUNT; i++)
	begin : g_rs
		alu_res_station i_rs
		(
			.clk, .rst_n,
			.load(rs_load[i]),
			.aluop(rs_aluop), .dest(rs_dest),
			.vj(rs_vj), .qj(rs_qj), .vj_valid(rs_vj_valid),
			.vk(rs_vk), .qk(rs_qk), .vk_valid(rs_vk_valid),
			.cdb_valid, .cdb_tag, .cdb_data,
			.grant(grant[i]),
			.busy(rs_busy[i]),
			.result_valid(result_valid[i]),
			.result_tag(),
			.result_data(result_data[i])
		);
	end

	cdb_arbiter i_arb
	(
		.clk, .rst_n, .result_valid, .result_data, .grant,
		.cdb_valid, .cdb_tag, .cdb_data
	);

endmodule

`default_nettype wire

// ==== logic/issue_unit.sv ====
`default_nettype none
`include "ooo_defs.svh"

module issue_unit
(
	input wire logic clk,
	input wire logic rst_n,
	input wire logic issue_valid,
	input wire lc3b_isa_pkg::lc3b_instr_u issue_instr,
	output logic issue_ready,
	input wire logic [`OOO_RS_COUNT-1:0] rs_busy,
	output logic [`OOO_RS_COUNT-1:0] rs_load,
	output lc3b_isa_pkg::lc3b_aluop rs_aluop,
	output ooo_pkg::rs_tag_t rs_dest,
	output lc3b_isa_pkg::lc3b_word rs_vj,
	output ooo_pkg::rs_tag_t rs_qj,
	output logic rs_vj_valid,
	output lc3b_isa_pkg::lc3b_word rs_vk,
	output ooo_pkg::rs_tag_t rs_qk,
	output logic rs_vk_valid,
	input wire logic cdb_valid,
	input wire ooo_pkg::rs_tag_t cdb_tag,
	input wire lc3b_isa_pkg::lc3b_word cdb_data
);

	import lc3b_isa_pkg::*;
	import ooo_pkg::*;

	lc3b_word reg_val [`OOO_REG_COUNT]; // Architectural values
	logic [`OOO_REG_COUNT-1:0] reg_pend; // A station will still write this register
	rs_tag_t reg_tag [`OOO_REG_COUNT]; // Station that will write it

	lc3b_opcode opcode;
	reg_idx_t dr;
	reg_idx_t sr1;
	reg_idx_t sr2;
	lc3b_word imm_sext;
	rs_tag_t alloc_tag; // Lowest free station
	logic fire; // Instruction accepted on this edge

	// True while the source still has to wait for its producer
	function automatic logic src_waiting(reg_idx_t idx);
		return reg_pend[idx] && !(cdb_valid && (cdb_tag == reg_tag[idx]));
	endfunction

	// Register value, or the CDB word when the producer is broadcasting now
	function automatic lc3b_word src_value(reg_idx_t idx);
		return reg_pend[idx] ? cdb_data : reg_val[idx];
	endfunction

	// **********************************************************************
	// Decode that picks the shift view by opcode
	// **********************************************************************

	assign opcode = issue_instr.oper.opcode; // Same position in both views
	assign dr = issue_instr.oper.dr;
	assign sr1 = issue_instr.oper.sr1;
	assign sr2 = issue_instr.oper.low5[2:0];
	assign imm_sext = {{(`OOO_DATA_WIDTH-5){issue_instr.oper.low5[4]}}, issue_instr.oper.low5};

	always_comb
	begin
		case (opcode)
			op_and: rs_aluop = alu_and;
			op_not: rs_aluop = alu_not;
			op_shf:
			begin
				// D picks the direction and A the fill of a right shift
				if (!issue_instr.shift.d_bit)
					rs_aluop = alu_lshf;
				else if (issue_instr.shift.a_bit)
					rs_aluop = alu_rshfa;
				else
					rs_aluop = alu_rshfl;
			end
			default: rs_aluop = alu_add;
		endcase
	end

	// Operand A always comes from sr1
	always_comb
	begin
		rs_vj = src_value(sr1);
		rs_qj = reg_tag[sr1];
		rs_vj_valid = !src_waiting(sr1);
	end

	always_comb
	begin
		rs_vk = src_value(sr2);
		rs_qk = reg_tag[sr2];
		rs_vk_valid = !src_waiting(sr2);
		if (opcode == op_not)
		begin
			rs_vk = '0; // NOT ignores operand B
			rs_vk_valid = 1'b1;
		end
		else if (opcode == op_shf)
		begin
			rs_vk = lc3b_word'(issue_instr.shift.amount);
			rs_vk_valid = 1'b1;
		end
		else if (issue_instr.oper.imm)
		begin
			rs_vk = imm_sext;
			rs_vk_valid = 1'b1;
		end
	end

	// **********************************************************************
	// Station allocation
	// **********************************************************************

	assign issue_ready = !(&rs_busy); // Any station free
	assign fire = issue_valid && issue_ready;
	assign rs_dest = alloc_tag;

	always_comb
	begin
		alloc_tag = '0;
		for (int i = `OOO_RS_COUNT - 1; i >= 0; i--)
		begin
			if (!rs_busy[i])
				alloc_tag = rs_tag_t'(i); // Lower index overrides
		end
		rs_load = '0;
		if (fire)
			rs_load[alloc_tag] = 1'b1;
	end

	// Retire from the CDB, then let a same-cycle rename take the register
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			reg_pend <= '0;
			for (int i = 0; i < `OOO_REG_COUNT; i++)
			begin
				reg_val[i] <= '0;
				reg_tag[i] <= '0;
			end
		end
		else
		begin
			for (int i = 0; i < `OOO_REG_COUNT; i++)
			begin
				if (cdb_valid && reg_pend[i] && (reg_tag[i] == cdb_tag))
				begin
					reg_val[i] <= cdb_data;
					reg_pend[i] <= 1'b0;
				end
			end
			if (fire)
			begin
				reg_pend[dr] <= 1'b1; // Later than the loop so it wins
				reg_tag[dr] <= alloc_tag;
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/cdb_arbiter.sv ====
`default_nettype none
`include "ooo_defs.svh"

module cdb_arbiter
(
	input wire logic clk,
	input wire logic rst_n,
	input wire logic [`OOO_RS_COUNT-1:0] result_valid,
	input wire lc3b_isa_pkg::lc3b_word result_data [`OOO_RS_COUNT],
	output logic [`OOO_RS_COUNT-1:0] grant,
	output logic cdb_valid,
	output ooo_pkg::rs_tag_t cdb_tag,
	output lc3b_isa_pkg::lc3b_word cdb_data
);

	import ooo_pkg::*;

	rs_tag_t sel; // Lowest requesting station
	logic any_req;

	assign any_req = |result_valid;

	// Fixed priority, station 0 highest
	always_comb
	begin
		sel = '0;
		for (int i = `OOO_RS_COUNT - 1; i >= 0; i--)
		begin
			if (result_valid[i])
				sel = rs_tag_t'(i);
		end
		grant = '0;
		if (any_req)
			grant[sel] = 1'b1;
	end

	// **********************************************************************
	// Broadcast register, one cycle behind the grant
	// **********************************************************************

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			cdb_valid <= 1'b0;
		else
			cdb_valid <= any_req;
	end

	always_ff @(posedge clk)
	begin
		cdb_tag <= sel; // Station index is the tag
		cdb_data <= result_data[sel];
	end

endmodule

`default_nettype wire

// ==== logic/alu_res_station.sv ====
`default_nettype none

module alu_res_station
(
	input wire logic clk,
	input wire logic rst_n,
	input wire logic load,
	input wire lc3b_isa_pkg::lc3b_aluop aluop,
	input wire ooo_pkg::rs_tag_t dest,
	input wire lc3b_isa_pkg::lc3b_word vj,
	input wire ooo_pkg::rs_tag_t qj,
	input wire logic vj_valid,
	input wire lc3b_isa_pkg::lc3b_word vk,
	input wire ooo_pkg::rs_tag_t qk,
	input wire logic vk_valid,
	input wire logic cdb_valid,
	input wire ooo_pkg::rs_tag_t cdb_tag,
	input wire lc3b_isa_pkg::lc3b_word cdb_data,
	input wire logic grant,
	output logic busy,
	output logic result_valid,
	output ooo_pkg::rs_tag_t result_tag,
	output lc3b_isa_pkg::lc3b_word result_data
);

	import lc3b_isa_pkg::*;
	import ooo_pkg::*;

	lc3b_aluop aluop_q;
	lc3b_word vj_q; // Operand A, value once vj_ok
	lc3b_word vk_q; // Operand B, value once vk_ok
	rs_tag_t qj_q; // Producer of A while it is missing
	rs_tag_t qk_q;
	logic vj_ok;
	logic vk_ok;
	logic capt_j; // CDB carries the missing A this cycle
	logic capt_k;

	assign capt_j = busy && !vj_ok && cdb_valid && (qj_q == cdb_tag);
	assign capt_k = busy && !vk_ok && cdb_valid && (qk_q == cdb_tag);

	// **********************************************************************
	// Occupancy and operand readiness
	// **********************************************************************

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			busy <= 1'b0;
			vj_ok <= 1'b0;
			vk_ok <= 1'b0;
		end
		else if (load)
		begin
			busy <= 1'b1;
			vj_ok <= vj_valid;
			vk_ok <= vk_valid;
		end
		else
		begin
			if (grant)
				busy <= 1'b0; // Result has been taken by the arbiter
			if (capt_j)
				vj_ok <= 1'b1;
			if (capt_k)
				vk_ok <= 1'b1;
		end
	end

	// Instruction fields and operand values
	always_ff @(posedge clk)
	begin
		if (load)
		begin
			aluop_q <= aluop;
			result_tag <= dest;
			vj_q <= vj;
			qj_q <= qj;
			vk_q <= vk;
			qk_q <= qk;
		end
		else
		begin
			if (capt_j)
				vj_q <= cdb_data;
			if (capt_k)
				vk_q <= cdb_data;
		end
	end

	// Held until granted, so a losing station simply waits
	assign result_valid = busy && vj_ok && vk_ok;

	lc3b_alu i_alu
	(
		.aluop(aluop_q),
		.a(vj_q),
		.b(vk_q),
		.f(result_data)
	);

endmodule

`default_nettype wire

// ==== logic/lc3b_alu.sv ====
`default_nettype none

module lc3b_alu
(
	input wire lc3b_isa_pkg::lc3b_aluop aluop,
	input wire lc3b_isa_pkg::lc3b_word a,
	input wire lc3b_isa_pkg::lc3b_word b,
	output lc3b_isa_pkg::lc3b_word f
);

	import lc3b_isa_pkg::*;

	logic [3:0] shamt; // LC-3b shifts take a 4-bit count

	assign shamt = b[3:0];

	always_comb
	begin
		case (aluop)
			alu_add: f = a + b;
			alu_and: f = a & b;
			alu_not: f = ~a; // Only operand A is used
			alu_lshf: f = a << shamt;
			alu_rshfl: f = a >> shamt; // Zero fill
			alu_rshfa: f = lc3b_word'($signed(a) >>> shamt); // Sign fill
			default: f = a;
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/ooo_pkg.sv ====
`default_nettype none
`include "ooo_defs.svh"

package ooo_pkg;

	// **********************************************************************
	// Renaming bookkeeping
	// **********************************************************************

	// A producer is named by the index of the station that holds it
	typedef logic [`OOO_TAG_WIDTH-1:0] rs_tag_t;

	typedef logic [$clog2(`OOO_REG_COUNT)-1:0] reg_idx_t; // Architectural register number

endpackage

`default_nettype wire

// ==== logic/lc3b_isa_pkg.sv ====
`default_nettype none
`include "ooo_defs.svh"

package lc3b_isa_pkg;

	typedef logic [`OOO_DATA_WIDTH-1:0] lc3b_word; // Data word on every datapath

	// Only the integer ALU opcodes are decoded by this core
	typedef enum logic [3:0]
	{
		op_add = 4'b0001,
		op_and = 4'b0101,
		op_not = 4'b1001,
		op_shf = 4'b1101
	} lc3b_opcode;

	typedef enum logic [2:0]
	{
		alu_add,
		alu_and,
		alu_not,
		alu_lshf,
		alu_rshfl,
		alu_rshfa
	} lc3b_aluop;

	// ADD, AND and NOT share this layout
	typedef struct packed
	{
		lc3b_opcode opcode;
		logic [2:0] dr;
		logic [2:0] sr1;
		logic imm; // Selects imm5 over sr2
		logic [4:0] low5; // imm5, or sr2 in its low three bits
	} lc3b_oper_t;

	typedef struct packed
	{
		lc3b_opcode opcode;
		logic [2:0] dr;
		logic [2:0] sr1;
		logic a_bit; // Arithmetic fill on a right shift
		logic d_bit; // Right shift when set
		logic [3:0] amount;
	} lc3b_shift_t;

	typedef union packed
	{
		lc3b_oper_t oper;
		lc3b_shift_t shift;
	} lc3b_instr_u;

endpackage

`default_nettype wire

// ==== include/ooo_defs.svh ====
`ifndef OOO_DEFS_SVH
`define OOO_DEFS_SVH

// **************************************************************************
// Core sizing for the ALU-only Tomasulo core
// **************************************************************************

`define OOO_DATA_WIDTH 16 // LC-3b machine word
`define OOO_TAG_WIDTH 2 // One tag per reservation station
`define OOO_RS_COUNT 4 // ALU reservation stations
`define OOO_REG_COUNT 8 // Architectural registers R0..R7

`endif
